// ==== hw/trig_pkg.sv ====
package trig_pkg;

	//////////////////////////////
	// Token and record widths
	//////////////////////////////
	localparam int TOKEN_W = 10;
	typedef logic [TOKEN_W-1:0] token_t;

	// Record layout: 5'b10000, error bit, token
	localparam int REC_W = 16;
	typedef logic [REC_W-1:0] rec_t;

	// Comma word sent while no token is pending
	localparam rec_t LINK_IDLE = 16'h00BC;

	//////////////////////////////
	// Serial frame
	//////////////////////////////
	// Token bits plus parity after the start bit
	localparam int FRAME_LEN = 11;

	typedef enum logic {
		IDLE,
		SHIFT
	} deser_state_t;

	// Record buffer
	localparam int FIFO_DEPTH = 16;
	typedef logic [$clog2(FIFO_DEPTH+1)-1:0] cnt_t;

	// LED on-time after the last event, in CLK125 cycles
	localparam int LED_HOLD = 1000;

	//////////////////////////////
	// Wishbone register map
	//////////////////////////////
	typedef logic [31:0] wb_data_t;
	localparam logic [1:0] REG_CSR   = 2'd0;
	localparam logic [1:0] REG_COUNT = 2'd1;
	localparam logic [1:0] REG_DATA  = 2'd2;

endpackage

// ==== hw/fifo_rd_if.sv ====
`timescale 1ns/1ps

interface fifo_rd_if;
	import trig_pkg::*;

	// Oldest record, shown without waiting for pop
	rec_t rd_data;
	// Fill level, 0 to FIFO_DEPTH
	cnt_t count;
	logic empty;
	// Sticky, set by a push into a full buffer
	logic overflow;
	// One-cycle strobes from the register side
	logic pop;
	logic ovf_clr;

	// Record buffer side
	modport buffer (
		output rd_data, count, empty, overflow,
		input  pop, ovf_clr
	);

	// Register block side
	modport host (
		input  rd_data, count, empty, overflow,
		output pop, ovf_clr
	);

endinterface

// ==== hw/trig_deser.sv ====
`timescale 1ns/1ps

module trig_deser (
	input  logic             CLK125,
	input  logic             reset_i,
	input  logic             ser_trig_i,
	output logic             tok_valid_o,
	output trig_pkg::token_t token_o,
	output logic             tok_err_o
);
	import trig_pkg::*;

	deser_state_t state_q;
	// Counts frame bits after the start bit
	logic [$clog2(FRAME_LEN)-1:0] bit_cnt_q;
	token_t shift_q;
	logic last_bit;

	// Parity bit is on the line in this cycle
	assign last_bit = (int'(bit_cnt_q) == FRAME_LEN - 1);

	//////////////////////////////
	// Frame FSM
	//////////////////////////////
	always_ff @(posedge CLK125) begin
		if (reset_i) begin
			state_q     <= IDLE;
			bit_cnt_q   <= '0;
			tok_valid_o <= 1'b0;
			tok_err_o   <= 1'b0;
		end else begin
			// Strobes by default
			tok_valid_o <= 1'b0;
			tok_err_o   <= 1'b0;
			case (state_q)
				IDLE: begin
					// Start bit
					if (ser_trig_i) begin
						state_q   <= SHIFT;
						bit_cnt_q <= '0;
					end
				end
				SHIFT: begin
					bit_cnt_q <= bit_cnt_q + 1'b1;
					if (last_bit) begin
						// Back to IDLE, next start bit taken right away
						state_q     <= IDLE;
						tok_valid_o <= 1'b1;
						// Odd parity over token and parity bit
						tok_err_o   <= ~(^{shift_q, ser_trig_i});
					end
				end
				default: state_q <= IDLE;
			endcase
		end
	end

	// Token shifter, MSB arrives first
	always_ff @(posedge CLK125) begin
		if (state_q == SHIFT) begin
			shift_q <= {shift_q[TOKEN_W-2:0], ser_trig_i};
			// Shifter holds all 10 token bits while parity is sampled
			if (last_bit) begin
				token_o <= shift_q;
			end
		end
	end

	// One pulse per frame, frames are at least 12 cycles apart
	a_valid_single: assert property (@(posedge CLK125) disable iff (reset_i)
		tok_valid_o |=> !tok_valid_o);

endmodule

// ==== hw/tok_sync.sv ====
`timescale 1ns/1ps

module tok_sync (
	input  logic             CLK125,
	input  logic             reset_i,
	input  logic             tok_valid_i,
	input  trig_pkg::token_t token_i,
	input  logic             tok_err_i,
	input  logic             enable_i,
	input  logic             sw_inhibit_i,
	input  logic             inhibit_i,
	output trig_pkg::rec_t   link_data_o,
	output logic             link_kchar_o,
	output logic             rec_valid_o,
	output trig_pkg::rec_t   rec_o
);
	import trig_pkg::*;

	rec_t status_w;
	logic accept;

	// Status word, marker bits then error flag then token
	assign status_w = {5'b10000, tok_err_i, token_i};

	// Acquisition gate
	assign accept = enable_i & ~sw_inhibit_i & ~inhibit_i;

	// Link echo, comma unless a token just came in
	always_ff @(posedge CLK125) begin
		if (reset_i) begin
			link_data_o  <= LINK_IDLE;
			link_kchar_o <= 1'b1;
			rec_valid_o  <= 1'b0;
		end else if (tok_valid_i) begin
			link_data_o  <= status_w;
			link_kchar_o <= 1'b0;
			// Echo goes out regardless of the gate
			rec_valid_o  <= accept;
		end else begin
			link_data_o  <= LINK_IDLE;
			link_kchar_o <= 1'b1;
			rec_valid_o  <= 1'b0;
		end
	end

	// Record is the word on the link in the same cycle
	assign rec_o = link_data_o;

	// A record is never a comma
	a_rec_not_comma: assert property (@(posedge CLK125) disable iff (reset_i)
		rec_valid_o |-> !link_kchar_o);

endmodule

// ==== hw/tok_fifo.sv ====
`timescale 1ns/1ps

module tok_fifo (
	input  logic             CLK125,
	input  logic             reset_i,
	input  logic             rec_valid_i,
	input  trig_pkg::rec_t   rec_i,
	fifo_rd_if.buffer        rd
);
	import trig_pkg::*;

	rec_t mem [FIFO_DEPTH];
	// Depth is a power of two, pointers wrap by themselves
	logic [$clog2(FIFO_DEPTH)-1:0] wr_ptr_q;
	logic [$clog2(FIFO_DEPTH)-1:0] rd_ptr_q;
	cnt_t count_q;
	logic overflow_q;
	logic full;
	logic do_push;
	logic do_pop;

	assign full    = (count_q == cnt_t'(FIFO_DEPTH));
	// Full buffer drops the record
	assign do_push = rec_valid_i & ~full;
	// Pop on empty is ignored
	assign do_pop  = rd.pop & ~rd.empty;

	// Read side
	assign rd.rd_data  = mem[rd_ptr_q];
	assign rd.count    = count_q;
	assign rd.empty    = (count_q == '0);
	assign rd.overflow = overflow_q;

	// Storage
	always_ff @(posedge CLK125) begin
		if (do_push) begin
			mem[wr_ptr_q] <= rec_i;
		end
	end

	// Pointers, level and overflow flag
	always_ff @(posedge CLK125) begin
		if (reset_i) begin
			wr_ptr_q   <= '0;
			rd_ptr_q   <= '0;
			count_q    <= '0;
			overflow_q <= 1'b0;
		end else begin
			if (do_push) wr_ptr_q <= wr_ptr_q + 1'b1;
			if (do_pop) rd_ptr_q <= rd_ptr_q + 1'b1;
			// Push and pop together keep the level
			case ({do_push, do_pop})
				2'b10:   count_q <= count_q + 1'b1;
				2'b01:   count_q <= count_q - 1'b1;
				default: count_q <= count_q;
			endcase
			// New overflow wins over a clear in the same cycle
			if (rec_valid_i && full) overflow_q <= 1'b1;
			else if (rd.ovf_clr) overflow_q <= 1'b0;
		end
	end

	a_count_range: assert property (@(posedge CLK125) disable iff (reset_i)
		count_q <= cnt_t'(FIFO_DEPTH));

endmodule

// ==== hw/wb_regs.sv ====
`timescale 1ns/1ps

module wb_regs (
	input  logic               CLK125,
	input  logic               reset_i,
	input  logic               wb_cyc_i,
	input  logic               wb_stb_i,
	input  logic               wb_we_i,
	input  logic [1:0]         wb_adr_i,
	input  trig_pkg::wb_data_t wb_dat_i,
	output trig_pkg::wb_data_t wb_dat_o,
	output logic               wb_ack_o,
	output logic               enable_o,
	output logic               sw_inhibit_o,
	fifo_rd_if.host            rd
);
	import trig_pkg::*;

	logic req;
	logic csr_wr;
	wb_data_t rd_mux;

	// New request, cycle with ack already up is skipped
	assign req    = wb_cyc_i & wb_stb_i & ~wb_ack_o;
	assign csr_wr = req & wb_we_i & (wb_adr_i == REG_CSR);

	//////////////////////////////
	// Read mux
	//////////////////////////////
	always_comb begin
		rd_mux = '0;
		case (wb_adr_i)
			// overflow, sw_inhibit, enable
			REG_CSR:   rd_mux = wb_data_t'({rd.overflow, sw_inhibit_o, enable_o});
			REG_COUNT: rd_mux = wb_data_t'(rd.count);
			// Zero when nothing is buffered
			REG_DATA: begin
				if (!rd.empty) rd_mux = wb_data_t'(rd.rd_data);
			end
			default:   rd_mux = '0;
		endcase
	end

	//////////////////////////////
	// Bus cycle and control bits
	//////////////////////////////
	always_ff @(posedge CLK125) begin
		if (reset_i) begin
			wb_ack_o     <= 1'b0;
			enable_o     <= 1'b0;
			sw_inhibit_o <= 1'b0;
			rd.pop       <= 1'b0;
			rd.ovf_clr   <= 1'b0;
		end else begin
			// Fixed one-cycle latency
			wb_ack_o   <= req;
			// Pop lands with ack, data already latched
			rd.pop     <= req & ~wb_we_i & (wb_adr_i == REG_DATA) & ~rd.empty;
			// Write 1 to bit 2 clears overflow
			rd.ovf_clr <= csr_wr & wb_dat_i[2];
			if (csr_wr) begin
				enable_o     <= wb_dat_i[0];
				sw_inhibit_o <= wb_dat_i[1];
			end
			// COUNT and DATA writes fall through
		end
	end

	// Read data register
	always_ff @(posedge CLK125) begin
		if (req) begin
			wb_dat_o <= rd_mux;
		end
	end

	a_ack_after_stb: assert property (@(posedge CLK125) disable iff (reset_i)
		wb_ack_o |-> $past(wb_cyc_i && wb_stb_i));

endmodule

// ==== hw/led_stretch.sv ====
`timescale 1ns/1ps

module led_stretch (
	input  logic CLK125,
	input  logic reset_i,
	input  logic event_i,
	output logic led_o
);
	import trig_pkg::*;

	// Remaining on-time
	logic [$clog2(LED_HOLD+1)-1:0] hold_q;

	always_ff @(posedge CLK125) begin
		if (reset_i) begin
			hold_q <= '0;
		end else if (event_i) begin
			// Each event restarts the full hold
			hold_q <= LED_HOLD[$clog2(LED_HOLD+1)-1:0];
		end else if (hold_q != '0) begin
			hold_q <= hold_q - 1'b1;
		end
	end

	// Lit for LED_HOLD cycles after the last event
	assign led_o = (hold_q != '0);

endmodule

// ==== hw/trig_top.sv ====
`timescale 1ns/1ps

module trig_top (
	input  logic               CLK125,
	input  logic               reset_i,
	input  logic               ser_trig_i,
	input  logic               inhibit_i,
	input  logic               wb_cyc_i,
	input  logic               wb_stb_i,
	input  logic               wb_we_i,
	input  logic [1:0]         wb_adr_i,
	input  trig_pkg::wb_data_t wb_dat_i,
	output trig_pkg::wb_data_t wb_dat_o,
	output logic               wb_ack_o,
	output trig_pkg::rec_t     link_data_o,
	output logic               link_kchar_o,
	output logic               led_trig_o,
	output logic               led_err_o
);
	import trig_pkg::*;

	// Capture to sync
	logic   tok_valid;
	token_t token;
	logic   tok_err;
	// Sync to buffer
	logic   rec_valid;
	rec_t   rec;
	// Control bits from CSR
	logic   enable;
	logic   sw_inhibit;

	fifo_rd_if rd_if ();

	//////////////////////////////
	// Token pipeline
	//////////////////////////////
	trig_deser u_deser (
		.CLK125      (CLK125),
		.reset_i     (reset_i),
		.ser_trig_i  (ser_trig_i),
		.tok_valid_o (tok_valid),
		.token_o     (token),
		.tok_err_o   (tok_err)
	);

	tok_sync u_sync (
		.CLK125       (CLK125),
		.reset_i      (reset_i),
		.tok_valid_i  (tok_valid),
		.token_i      (token),
		.tok_err_i    (tok_err),
		.enable_i     (enable),
		.sw_inhibit_i (sw_inhibit),
		.inhibit_i    (inhibit_i),
		.link_data_o  (link_data_o),
		.link_kchar_o (link_kchar_o),
		.rec_valid_o  (rec_valid),
		.rec_o        (rec)
	);

	tok_fifo u_fifo (
		.CLK125      (CLK125),
		.reset_i     (reset_i),
		.rec_valid_i (rec_valid),
		.rec_i       (rec),
		.rd          (rd_if)
	);

	// Register access
	wb_regs u_regs (
		.CLK125       (CLK125),
		.reset_i      (reset_i),
		.wb_cyc_i     (wb_cyc_i),
		.wb_stb_i     (wb_stb_i),
		.wb_we_i      (wb_we_i),
		.wb_adr_i     (wb_adr_i),
		.wb_dat_i     (wb_dat_i),
		.wb_dat_o     (wb_dat_o),
		.wb_ack_o     (wb_ack_o),
		.enable_o     (enable),
		.sw_inhibit_o (sw_inhibit),
		.rd           (rd_if)
	);

	// Front panel LEDs
	led_stretch led_trig (
		.CLK125  (CLK125),
		.reset_i (reset_i),
		.event_i (tok_valid),
		.led_o   (led_trig_o)
	);

	// Error strobe only comes with a token
	led_stretch led_err (
		.CLK125  (CLK125),
		.reset_i (reset_i),
		.event_i (tok_err),
		.led_o   (led_err_o)
	);

endmodule

// ==== tb/tb_clkgen.sv ====
`timescale 1ns/1ps

module tb_clkgen (
	output logic CLK125,
	output logic reset_o
);

	// 20 ns period in simulation
	initial begin
		CLK125 = 1'b0;
		forever #10 CLK125 = ~CLK125;
	end

	// Held for four rising edges
	initial begin
		reset_o = 1'b1;
		repeat (4) @(posedge CLK125);
		reset_o <= 1'b0;
	end

endmodule

// ==== tb/tb_trig_top.sv ====
`timescale 1ns/1ps

module tb_trig_top;
	import trig_pkg::*;

	//////////////////////////////
	// Test lengths and timing
	//////////////////////////////
	localparam int N_DISABLED = 4;
	localparam int N_RECORD   = 8;
	localparam int N_INHIBIT  = 3;
	localparam int N_OVER     = FIFO_DEPTH + 4;
	localparam int N_LED      = 2;
	localparam int N_FRAMES   = N_DISABLED + N_RECORD + 2 * N_INHIBIT + N_OVER + N_LED;
	// Start, token, parity, line low, plus settle
	localparam int FRAME_CYC  = 17;
	localparam int MAX_GAP    = 7;
	localparam int N_ACCESS   = 80;
	localparam int ACCESS_CYC = 5;
	localparam int LED_CYC    = 3 * (LED_HOLD + 10);
	localparam int WATCHDOG_CYC =
		2 * (N_FRAMES * (FRAME_CYC + MAX_GAP) + N_ACCESS * ACCESS_CYC + LED_CYC);

	logic     CLK125;
	logic     reset;
	// DUT inputs, idle values at time zero
	logic     ser_trig = 1'b0;
	logic     inhibit  = 1'b0;
	logic     wb_cyc   = 1'b0;
	logic     wb_stb   = 1'b0;
	logic     wb_we    = 1'b0;
	logic [1:0] wb_adr = 2'd0;
	wb_data_t wb_dat_w = '0;
	// DUT outputs
	wb_data_t wb_dat_r;
	logic     wb_ack;
	rec_t     link_data;
	logic     link_kchar;
	logic     led_trig;
	logic     led_err;

	int   seed = 32'h805e_f4ec;
	int   cycle_cnt = 0;
	int   err_cnt = 0;
	// Shadow of the CSR as the DUT should hold it
	logic en_q = 1'b0;
	logic swinh_q = 1'b0;
	logic exp_ovf = 1'b0;
	// Expected link echoes, sample cycle and word
	int   exp_time[$];
	rec_t exp_link[$];
	// Expected FIFO contents
	rec_t exp_rec[$];

	tb_clkgen u_clkgen (
		.CLK125  (CLK125),
		.reset_o (reset)
	);

	trig_top dut (
		.CLK125       (CLK125),
		.reset_i      (reset),
		.ser_trig_i   (ser_trig),
		.inhibit_i    (inhibit),
		.wb_cyc_i     (wb_cyc),
		.wb_stb_i     (wb_stb),
		.wb_we_i      (wb_we),
		.wb_adr_i     (wb_adr),
		.wb_dat_i     (wb_dat_w),
		.wb_dat_o     (wb_dat_r),
		.wb_ack_o     (wb_ack),
		.link_data_o  (link_data),
		.link_kchar_o (link_kchar),
		.led_trig_o   (led_trig),
		.led_err_o    (led_err)
	);

	always @(posedge CLK125) cycle_cnt <= cycle_cnt + 1;

	// Marker 10000, error flag, token
	function automatic rec_t exp_record(input token_t tok, input logic err);
		exp_record = {5'b10000, err, tok};
	endfunction

	task automatic value_error(input string what, input wb_data_t got, input wb_data_t exp_val);
		err_cnt++;
		$display("Error at %0t ns: %s is %h, expected %h", $time, what, got, exp_val);
		$display("Finished with errors");
		$fatal(1, "Stopped at first mismatch");
	endtask

	task automatic hard_fail(input string msg);
		$display("%s", msg);
		$display("Finished with errors");
		$fatal(1, "Run aborted");
	endtask

	task automatic check_eq(input string what, input wb_data_t got, input wb_data_t exp_val);
		assert (got == exp_val) else value_error(what, got, exp_val);
	endtask

	//////////////////////////////
	// Wishbone master
	//////////////////////////////
	task automatic wb_access(input logic we, input logic [1:0] adr, input wb_data_t wdat,
			output wb_data_t rdat);
		int wait_cnt;
		wait_cnt = 0;
		@(posedge CLK125);
		wb_cyc   <= 1'b1;
		wb_stb   <= 1'b1;
		wb_we    <= we;
		wb_adr   <= adr;
		wb_dat_w <= wdat;
		// Hold request until ack
		do begin
			@(negedge CLK125);
			wait_cnt++;
			if (wait_cnt > 4) begin
				hard_fail("Wishbone slave gave no acknowledge within 4 cycles");
			end
		end while (!wb_ack);
		check_eq("Wishbone ack latency", wb_data_t'(wait_cnt), 32'd2);
		rdat = wb_dat_r;
		@(posedge CLK125);
		wb_cyc <= 1'b0;
		wb_stb <= 1'b0;
		wb_we  <= 1'b0;
	endtask

	task automatic set_csr(input logic en, input logic swinh, input logic clr);
		wb_data_t unused;
		wb_access(1'b1, REG_CSR, {29'd0, clr, swinh, en}, unused);
		en_q    = en;
		swinh_q = swinh;
		if (clr) exp_ovf = 1'b0;
	endtask

	task automatic check_csr();
		wb_data_t rdat;
		wb_access(1'b0, REG_CSR, '0, rdat);
		check_eq("CSR", rdat, {29'd0, exp_ovf, swinh_q, en_q});
	endtask

	task automatic check_count();
		wb_data_t rdat;
		wb_access(1'b0, REG_COUNT, '0, rdat);
		check_eq("COUNT", rdat, wb_data_t'(exp_rec.size()));
	endtask

	// COUNT then DATA until empty, then one read on the empty FIFO
	task automatic drain_check();
		wb_data_t rdat;
		while (exp_rec.size() > 0) begin
			check_count();
			wb_access(1'b0, REG_DATA, '0, rdat);
			check_eq("DATA", rdat, wb_data_t'(exp_rec.pop_front()));
		end
		wb_access(1'b0, REG_DATA, '0, rdat);
		check_eq("DATA on empty FIFO", rdat, '0);
	endtask

	//////////////////////////////
	// Serial frames
	//////////////////////////////
	task automatic send_frame(input token_t tok, input logic bad, input int gap);
		logic parity;
		// Odd parity, optionally flipped
		parity = ~(^tok) ^ bad;
		@(posedge CLK125);
		ser_trig <= 1'b1;
		// MSB first
		for (int i = TOKEN_W - 1; i >= 0; i--) begin
			@(posedge CLK125);
			ser_trig <= tok[i];
		end
		@(posedge CLK125);
		ser_trig <= parity;
		// Echo two cycles after parity, seen at the falling edge
		exp_time.push_back(cycle_cnt + 3);
		exp_link.push_back(exp_record(tok, bad));
		if (en_q && !swinh_q && !inhibit) begin
			if (exp_rec.size() < FIFO_DEPTH) exp_rec.push_back(exp_record(tok, bad));
			else exp_ovf = 1'b1;
		end
		@(posedge CLK125);
		ser_trig <= 1'b0;
		repeat (gap) @(posedge CLK125);
	endtask

	task automatic send_random(input int n);
		token_t tok;
		logic   bad;
		int     gap;
		for (int i = 0; i < n; i++) begin
			tok = token_t'($random(seed));
			// Second frame of a burst always carries a parity error
			bad = (i == 1) || (($random(seed) & 3) == 0);
			gap = $unsigned($random(seed)) % (MAX_GAP + 1);
			send_frame(tok, bad, gap);
		end
		// Let the last record reach the count
		repeat (4) @(posedge CLK125);
	endtask

	// Link echo check on every falling edge
	always @(negedge CLK125) begin
		if (!reset) begin
			if (exp_time.size() != 0 && exp_time[0] == cycle_cnt) begin
				assert (link_data == exp_link[0] && !link_kchar)
					else value_error("link status word", wb_data_t'({link_kchar, link_data}),
						wb_data_t'({1'b0, exp_link[0]}));
				exp_time.pop_front();
				exp_link.pop_front();
			end else begin
				assert (link_data == LINK_IDLE && link_kchar)
					else value_error("idle link word", wb_data_t'({link_kchar, link_data}),
						wb_data_t'({1'b1, LINK_IDLE}));
			end
		end
	end

	// Watchdog
	initial begin
		repeat (WATCHDOG_CYC) @(posedge CLK125);
		hard_fail("Timeout: the test did not finish within the watchdog limit");
	end

	//////////////////////////////
	// Test sequence
	//////////////////////////////
	initial begin
		@(negedge CLK125);
		while (reset) @(negedge CLK125);
		// State after reset
		check_eq("led_trig after reset", wb_data_t'(led_trig), '0);
		check_eq("led_err after reset", wb_data_t'(led_err), '0);
		check_csr();
		check_count();

		// Enable clear, echo only
		send_random(N_DISABLED);
		check_count();

		// Record path
		set_csr(1'b1, 1'b0, 1'b0);
		send_random(N_RECORD);
		drain_check();

		// Software inhibit
		set_csr(1'b1, 1'b1, 1'b0);
		send_random(N_INHIBIT);
		check_count();
		set_csr(1'b1, 1'b0, 1'b0);
		// External inhibit
		@(posedge CLK125);
		inhibit <= 1'b1;
		send_random(N_INHIBIT);
		check_count();
		@(posedge CLK125);
		inhibit <= 1'b0;

		// Overflow, more frames than the FIFO holds
		send_random(N_OVER);
		check_csr();
		drain_check();
		set_csr(1'b1, 1'b0, 1'b1);
		check_csr();

		// LEDs, wait until both are dark
		repeat (LED_HOLD + 10) @(negedge CLK125);
		check_eq("led_trig idle", wb_data_t'(led_trig), '0);
		check_eq("led_err idle", wb_data_t'(led_err), '0);
		send_frame(token_t'($random(seed)), 1'b0, 0);
		repeat (4) @(negedge CLK125);
		check_eq("led_trig after frame", wb_data_t'(led_trig), 32'd1);
		check_eq("led_err after good frame", wb_data_t'(led_err), '0);
		repeat (LED_HOLD + 5) @(negedge CLK125);
		check_eq("led_trig after hold", wb_data_t'(led_trig), '0);
		send_frame(token_t'($random(seed)), 1'b1, 0);
		repeat (4) @(negedge CLK125);
		check_eq("led_err after parity error", wb_data_t'(led_err), 32'd1);

		// All echoes must have shown up
		repeat (8) @(negedge CLK125);
		check_eq("missing link echoes", wb_data_t'(exp_time.size()), '0);

		if (err_cnt == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

// ==== filelist.f ====
hw/trig_pkg.sv
hw/fifo_rd_if.sv
hw/trig_deser.sv
hw/tok_sync.sv
hw/tok_fifo.sv
hw/wb_regs.sv
hw/led_stretch.sv
hw/trig_top.sv
tb/tb_clkgen.sv
tb/tb_trig_top.sv

// ==== Bender.yml ====
package:
  name: trig_token

sources:
  - hw/trig_pkg.sv
  - hw/fifo_rd_if.sv
  - hw/trig_deser.sv
  - hw/tok_sync.sv
  - hw/tok_fifo.sv
  - hw/wb_regs.sv
  - hw/led_stretch.sv
  - hw/trig_top.sv
  - target: test
    files:
      - tb/tb_clkgen.sv
      - tb/tb_trig_top.sv
